// ==== files.f ====
+incdir+rtl
rtl/ym_pkg.sv
rtl/ym_prims.sv
rtl/ym_slot_clock.sv
rtl/ym_reg_if.sv
rtl/ym_phase_lane.sv
rtl/ym_phase_tap.sv
rtl/ym_top.sv
tb/ym_asserts.sv
tb/ym_tb.sv

// ==== tb/ym_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ym_params.svh"

module ym_tb;

	// about 250 reads and 70 writes of under 40 cycles each plus at most 60 stepped rounds
	localparam int CYCLE_LIMIT = 40000;
	localparam logic [31:0] SEED = 32'h764eda49;

	logic MCLK;
	logic rst;
	logic [11:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [11:0] araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;

	logic [`YM_PHASE_W-1:0] model_freq [`YM_LANES][`YM_SLOTS];
	logic [`YM_PHASE_W-1:0] model_phase [`YM_LANES][`YM_SLOTS];
	int cycles;
	int checks;
	int errors;
	int test_num;
	int test_errors;
	int bdelay_max;
	int rdelay_max;

	ym_top i_dut (.*);

	always #4 MCLK = ~MCLK;

	always @(posedge MCLK)
	begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("Timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
			$display("Testbench failed");
			$finish;
		end
	end

	// word index is lane times 8 plus slot, one 32-bit word each
	function automatic logic [11:0] word_addr(input logic [11:0] base, input int lane,
		input int slot);
		return base + 12'((lane * 8 + slot) * 4);
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("Mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic report_test(input string name);
		test_num++;
		$display("test %0d %s: %0d errors", test_num, name, errors - test_errors);
		test_errors = errors;
	endtask

	task automatic write_reg(input logic [11:0] addr, input logic [31:0] data);
		int delay;
		@(posedge MCLK);
		awaddr <= addr;
		wdata <= data;
		awvalid <= 1'b1;
		wvalid <= 1'b1;
		do
			@(negedge MCLK);
		while (!(awready && wready));
		@(posedge MCLK);
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		do
			@(negedge MCLK);
		while (!bvalid);
		check_value("bresp", 32'(bresp), 32'd0);
		delay = $urandom_range(bdelay_max, 0);
		repeat (delay) @(posedge MCLK);
		@(posedge MCLK);
		bready <= 1'b1;
		@(posedge MCLK); // response taken on this edge
		bready <= 1'b0;
	endtask

	task automatic read_reg(input logic [11:0] addr, output logic [31:0] data);
		int delay;
		@(posedge MCLK);
		araddr <= addr;
		arvalid <= 1'b1;
		do
			@(negedge MCLK);
		while (!arready);
		@(posedge MCLK);
		arvalid <= 1'b0;
		do
			@(negedge MCLK);
		while (!rvalid);
		delay = $urandom_range(rdelay_max, 0);
		repeat (delay) @(posedge MCLK);
		@(posedge MCLK);
		rready <= 1'b1;
		@(negedge MCLK);
		data = rdata; // rvalid still holds the data here
		check_value("rresp", 32'(rresp), 32'd0);
		@(posedge MCLK);
		rready <= 1'b0;
	endtask

	task automatic write_fnum(input int lane, input int slot, input logic [`YM_PHASE_W-1:0] value);
		write_reg(word_addr(`YM_ADDR_FNUM_BASE, lane, slot), 32'(value));
		model_freq[lane][slot] = value;
	endtask

	task automatic advance_model(input int n);
		for (int l = 0; l < `YM_LANES; l++)
			for (int s = 0; s < `YM_SLOTS; s++)
				model_phase[l][s] = model_phase[l][s] + 12'(n) * model_freq[l][s];
	endtask

	task automatic wait_idle();
		logic [31:0] v;
		do
			read_reg(`YM_ADDR_STEP, v);
		while (v[31]);
		check_value("rdata step count", v, 32'd0);
	endtask

	task automatic run_steps(input int n);
		write_reg(`YM_ADDR_STEP, 32'(n));
		wait_idle();
		advance_model(n);
	endtask

	task automatic check_all_phases(input bit shuffle);
		int order [`YM_LANES * `YM_SLOTS];
		int j;
		int tmp;
		int l;
		int s;
		logic [31:0] v;
		for (int k = 0; k < `YM_LANES * `YM_SLOTS; k++)
			order[k] = k;
		if (shuffle)
		begin
			for (int k = `YM_LANES * `YM_SLOTS - 1; k > 0; k--)
			begin
				j = $urandom_range(k, 0);
				tmp = order[k];
				order[k] = order[j];
				order[j] = tmp;
			end
		end
		for (int k = 0; k < `YM_LANES * `YM_SLOTS; k++)
		begin
			l = order[k] / `YM_SLOTS;
			s = order[k] % `YM_SLOTS;
			read_reg(word_addr(`YM_ADDR_PHASE_BASE, l, s), v);
			check_value($sformatf("rdata phase[%0d][%0d]", l, s), v, 32'(model_phase[l][s]));
		end
	endtask

	initial
	begin
		logic [31:0] v;
		int n1;
		int n2;
		void'($urandom(SEED));
		MCLK = 1'b0;
		rst = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		cycles = 0;
		checks = 0;
		errors = 0;
		test_num = 0;
		test_errors = 0;
		bdelay_max = 0;
		rdelay_max = 0;
		for (int l = 0; l < `YM_LANES; l++)
			for (int s = 0; s < `YM_SLOTS; s++)
			begin
				model_freq[l][s] = '0;
				model_phase[l][s] = '0;
			end
		repeat (8) @(posedge MCLK);
		rst <= 1'b0;

		// the first reads are held off until the clearing round after reset is over
		check_all_phases(1'b0);
		read_reg(`YM_ADDR_STEP, v);
		check_value("rdata step", v, 32'd0);
		report_test("reset state");

		for (int l = 0; l < `YM_LANES; l++)
			for (int s = 0; s < `YM_SLOTS; s++)
				write_fnum(l, s, 12'($urandom));
		run_steps(1);
		check_all_phases(1'b0);
		report_test("frequency write and one round");

		n1 = $urandom_range(20, 1);
		run_steps(n1);
		check_all_phases(1'b0);
		report_test("multi-round stepping");

		write_reg(`YM_ADDR_CTRL, 32'd1);
		write_reg(`YM_ADDR_CTRL, 32'd0); // accepted only after the clearing round
		for (int l = 0; l < `YM_LANES; l++)
			for (int s = 0; s < `YM_SLOTS; s++)
				model_phase[l][s] = '0;
		check_all_phases(1'b1);
		run_steps(1);
		check_all_phases(1'b0);
		report_test("clear");

		n1 = $urandom_range(8, 2);
		n2 = n1 + $urandom_range(10, 1);
		write_reg(`YM_ADDR_STEP, 32'(n1));
		read_reg(`YM_ADDR_STEP, v);
		check_value("rdata step busy", 32'(v[31]), 32'd1);
		write_reg(`YM_ADDR_STEP, 32'(n2));
		wait_idle();
		advance_model(n1);
		check_all_phases(1'b0);
		report_test("busy rejection");

		bdelay_max = 6;
		rdelay_max = 6;
		for (int k = 0; k < 8; k++)
			write_fnum($urandom_range(`YM_LANES - 1, 0), $urandom_range(`YM_SLOTS - 1, 0),
				12'($urandom));
		run_steps($urandom_range(5, 1));
		check_all_phases(1'b1);
		report_test("back-pressure");

		errors = errors + i_dut.i_reg_if.i_asserts.fails;
		$display("Summary: %0d tests, %0d checks, %0d errors", test_num, checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/ym_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none

module ym_asserts import ym_pkg::*;
	(
	input logic MCLK,
	input logic rst,
	input logic awvalid,
	input logic awready,
	input logic wvalid,
	input logic wready,
	input logic bvalid,
	input logic bready,
	input logic arvalid,
	input logic arready,
	input logic rvalid,
	input logic rready,
	input ym_tick_t tick
	);

	int fails = 0;

	// a valid that is not yet accepted stays up on the next edge
	aw_hold: assert property (@(posedge MCLK) disable iff (rst) awvalid && !awready |=> awvalid)
		else
		begin
			fails++;
			$error("awvalid dropped before awready");
		end
	w_hold: assert property (@(posedge MCLK) disable iff (rst) wvalid && !wready |=> wvalid)
		else
		begin
			fails++;
			$error("wvalid dropped before wready");
		end
	ar_hold: assert property (@(posedge MCLK) disable iff (rst) arvalid && !arready |=> arvalid)
		else
		begin
			fails++;
			$error("arvalid dropped before arready");
		end
	b_hold: assert property (@(posedge MCLK) disable iff (rst) bvalid && !bready |=> bvalid)
		else
		begin
			fails++;
			$error("bvalid dropped before bready");
		end
	r_hold: assert property (@(posedge MCLK) disable iff (rst) rvalid && !rready |=> rvalid)
		else
		begin
			fails++;
			$error("rvalid dropped before rready");
		end

	// six slots of two cycles each separate one round start from the next
	round_len: assert property (@(posedge MCLK) disable iff (rst)
		tick.round_start |=> !tick.round_start [*11] ##1 tick.round_start)
		else
		begin
			fails++;
			$error("round start did not repeat after exactly 12 cycles");
		end
	slot_range: assert property (@(posedge MCLK) disable iff (rst) tick.slot < 3'd6)
		else
		begin
			fails++;
			$error("slot counter left the range 0 to 5");
		end

	// the response channels are idle once reset has been applied
	resp_reset: assert property (@(posedge MCLK) rst |=> !bvalid && !rvalid)
		else
		begin
			fails++;
			$error("response valid high during reset");
		end

endmodule

bind ym_reg_if ym_asserts i_asserts (.*);

`default_nettype wire

// ==== rtl/ym_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ym_params.svh"

module ym_top import ym_pkg::*;
	(
	input logic MCLK,
	input logic rst,
	input logic [11:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [31:0] wdata,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [11:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready
	);

	ym_tick_t tick;
	ym_lane_cmd_t cmd;
	ym_tap_req_t tap_req;
	logic step_active;
	logic tap_done;
	logic [`YM_PHASE_W-1:0] tap_data;
	logic [`YM_LANES-1:0][`YM_PHASE_W-1:0] lane_phase;

	ym_slot_clock i_clk (.MCLK(MCLK), .rst(rst), .tick(tick));

	ym_reg_if i_reg_if
		(
		.MCLK(MCLK),
		.rst(rst),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.tick(tick),
		.cmd(cmd),
		.step_active(step_active),
		.tap_req(tap_req),
		.tap_done(tap_done),
		.tap_data(tap_data)
		);

	genvar i;

	generate
		for (i = 0; i < `YM_LANES; i++)
		begin : g_lane
			ym_phase_lane #(.LANE_ID(i)) i_lane
				(
				.MCLK(MCLK),
				.rst(rst),
				.tick(tick),
				.cmd(cmd),
				.step_active(step_active),
				.phase(lane_phase[i])
				);
		end
	endgenerate

	ym_phase_tap i_tap
		(
		.MCLK(MCLK),
		.rst(rst),
		.tick(tick),
		.lane_phase(lane_phase),
		.req(tap_req),
		.done(tap_done),
		.data(tap_data)
		);

endmodule

`default_nettype wire

// ==== rtl/ym_phase_tap.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ym_params.svh"

module ym_phase_tap import ym_pkg::*;
	(
	input logic MCLK,
	input logic rst,
	input ym_tick_t tick,
	input logic [`YM_LANES-1:0][`YM_PHASE_W-1:0] lane_phase,
	input ym_tap_req_t req,
	output logic done,
	output logic [`YM_PHASE_W-1:0] data
	);

	logic cap;

	assign cap = req.valid & tick.c2 & (tick.slot == req.slot) & ~done;

	// the snapshot lands in the slave stage one cycle after cap, together with done
	ym_dbg_read #(.DATA_WIDTH(`YM_PHASE_W)) i_snap
		(
		.MCLK(MCLK),
		.rst(rst),
		.c1(cap),
		.c2(done),
		.load(cap),
		.load_val(lane_phase[req.lane]),
		.val(data)
		);

	always_ff @(posedge MCLK)
	begin
		if (rst)
			done <= 1'b0;
		else
			done <= cap;
	end

endmodule

`default_nettype wire

// ==== rtl/ym_phase_lane.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ym_params.svh"

module ym_phase_lane import ym_pkg::*; #(parameter int LANE_ID = 0)
	(
	input logic MCLK,
	input logic rst,
	input ym_tick_t tick,
	input ym_lane_cmd_t cmd,
	input logic step_active,
	output logic [`YM_PHASE_W-1:0] phase
	);

	logic [`YM_PHASE_W-1:0] fr_in;
	logic [`YM_PHASE_W-1:0] fr_out;
	logic [`YM_PHASE_W-1:0] ph_in;
	logic [`YM_PHASE_W-1:0] ph_out;
	logic fnum_hit;

	assign fnum_hit = (cmd.op == OP_FNUM) && (cmd.lane == 2'(LANE_ID)) && (cmd.slot == tick.slot);

	// during c1 the ring outputs show the words stored for the current slot
	ym_sr_bit_array #(.SR_LENGTH(`YM_SLOTS), .DATA_WIDTH(`YM_PHASE_W)) i_fnum_ring
		(
		.MCLK(MCLK),
		.rst(rst),
		.c1(tick.c1),
		.c2(tick.c2),
		.data_in(fr_in),
		.data_out(fr_out)
		);

	ym_sr_bit_array #(.SR_LENGTH(`YM_SLOTS), .DATA_WIDTH(`YM_PHASE_W)) i_phase_ring
		(
		.MCLK(MCLK),
		.rst(rst),
		.c1(tick.c1),
		.c2(tick.c2),
		.data_in(ph_in),
		.data_out(ph_out)
		);

	assign fr_in = fnum_hit ? cmd.value : fr_out;
	assign ph_in = (cmd.op == OP_CLEAR) ? '0 : (step_active ? ph_out + fr_in : ph_out);

	// holds the new phase of the slot through its c2 cycle
	always_ff @(posedge MCLK)
	begin
		if (rst)
			phase <= '0;
		else if (tick.c1)
			phase <= ph_in;
	end

endmodule

`default_nettype wire

// ==== rtl/ym_reg_if.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ym_params.svh"

module ym_reg_if import ym_pkg::*;
	(
	input logic MCLK,
	input logic rst,
	input logic [11:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [31:0] wdata,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [11:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,
	input ym_tick_t tick,
	output ym_lane_cmd_t cmd,
	output logic step_active,
	output ym_tap_req_t tap_req,
	input logic tap_done,
	input logic [`YM_PHASE_W-1:0] tap_data
	);

	ym_axi_state_e state;
	logic init_clr; // post-reset clearing round still running
	logic clr_wait;
	logic step_pend;
	logic [`YM_STEP_W-1:0] step_n;
	logic [`YM_STEP_W-1:0] count;
	logic [1:0] rd_lane;
	logic [2:0] rd_slot;
	logic wr_fire;
	logic rd_fire;
	logic busy;

	assign wr_fire = awvalid & awready & wvalid & wready;
	assign rd_fire = arvalid & arready;
	assign step_active = (count != '0);
	assign busy = step_pend | step_active;

	// round counter steps once per round, a decrement is a load of count plus all ones
	ym_cnt_bit_load #(.DATA_WIDTH(`YM_STEP_W)) i_round_cnt
		(
		.MCLK(MCLK),
		.rst(rst),
		.c1(tick.round_start),
		.c2(tick.c2 & (tick.slot == 3'd0)),
		.c_in(1'b0),
		.clear(init_clr),
		.load(busy),
		.load_val(step_pend ? step_n : count + {`YM_STEP_W{1'b1}}),
		.val(count),
		.c_out()
		);

	always_ff @(posedge MCLK)
	begin
		if (rst)
		begin
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
			cmd.op <= OP_NONE;
			clr_wait <= 1'b1;
			init_clr <= 1'b1;
			step_pend <= 1'b0;
		end
		else
		begin
			if (awready)
			begin
				awready <= 1'b0;
				wready <= 1'b0;
			end
			else if (awvalid & wvalid & ~bvalid & ~init_clr & ~clr_wait & (cmd.op == OP_NONE))
			begin
				awready <= 1'b1;
				wready <= 1'b1;
			end

			if (wr_fire)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;

			// an FNUM command waits for the c1 of its slot
			if (cmd.op == OP_FNUM && tick.c1 && tick.slot == cmd.slot)
				cmd.op <= OP_NONE;

			// clearing spans slots 1..5 and then slot 0 of the following round start
			if (tick.round_start)
			begin
				step_pend <= 1'b0;
				if (cmd.op == OP_CLEAR)
				begin
					cmd.op <= OP_NONE;
					init_clr <= 1'b0;
				end
				else if (clr_wait)
				begin
					cmd.op <= OP_CLEAR;
					clr_wait <= 1'b0;
				end
			end

			if (wr_fire)
			begin
				if ((awaddr & `YM_ADDR_REGION_MASK) == `YM_ADDR_FNUM_BASE)
				begin
					if (awaddr[4:2] < 3'(`YM_SLOTS))
						cmd.op <= OP_FNUM;
				end
				else if (awaddr == `YM_ADDR_CTRL)
					clr_wait <= wdata[0];
				else if (awaddr == `YM_ADDR_STEP && !busy)
					step_pend <= 1'b1;
			end
		end
	end

	// command payload and step value carry no reset
	always_ff @(posedge MCLK)
	begin
		if (wr_fire)
		begin
			if ((awaddr & `YM_ADDR_REGION_MASK) == `YM_ADDR_FNUM_BASE)
			begin
				cmd.lane <= awaddr[6:5];
				cmd.slot <= awaddr[4:2];
				cmd.value <= wdata[`YM_PHASE_W-1:0];
			end
			if (awaddr == `YM_ADDR_STEP && !busy)
				step_n <= wdata[`YM_STEP_W-1:0];
		end
	end

	always_ff @(posedge MCLK)
	begin
		if (rst)
		begin
			state <= AX_IDLE;
			arready <= 1'b0;
		end
		else
		begin
			arready <= 1'b0;
			case (state)
				AX_IDLE:
				begin
					if (rd_fire)
					begin
						rd_lane <= araddr[6:5];
						rd_slot <= araddr[4:2];
						rdata <= '0;
						if ((araddr & `YM_ADDR_REGION_MASK) == `YM_ADDR_PHASE_BASE
							&& araddr[4:2] < 3'(`YM_SLOTS))
							state <= AX_WAIT_TAP;
						else
						begin
							if (araddr == `YM_ADDR_STEP)
								rdata <= {busy, 23'd0, count};
							state <= AX_RESP;
						end
					end
					else if (arvalid & ~arready & ~init_clr)
						arready <= 1'b1;
				end
				AX_WAIT_TAP:
				begin
					if (tap_done)
					begin
						rdata <= {{(32 - `YM_PHASE_W){1'b0}}, tap_data};
						state <= AX_RESP;
					end
				end
				AX_RESP:
				begin
					if (rready)
						state <= AX_IDLE;
				end
				default: state <= AX_IDLE;
			endcase
		end
	end

	assign rvalid = (state == AX_RESP);
	assign rresp = 2'b00;
	assign bresp = 2'b00;
	assign tap_req.valid = (state == AX_WAIT_TAP);
	assign tap_req.lane = rd_lane;
	assign tap_req.slot = rd_slot;

endmodule

`default_nettype wire

// ==== rtl/ym_slot_clock.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ym_params.svh"

module ym_slot_clock import ym_pkg::*;
	(
	input logic MCLK,
	input logic rst,
	output ym_tick_t tick
	);

	logic ph; // low in the c1 cycle, high in the c2 cycle
	logic [2:0] slot;

	always_ff @(posedge MCLK)
	begin
		if (rst)
		begin
			ph <= 1'b0;
			slot <= '0;
		end
		else
		begin
			ph <= ~ph;
			if (ph)
				slot <= (slot == 3'(`YM_SLOTS - 1)) ? 3'd0 : slot + 3'd1;
		end
	end

	assign tick.c1 = ~ph;
	assign tick.c2 = ph;
	assign tick.slot = slot;
	assign tick.round_start = ~ph & (slot == 3'd0);

endmodule

`default_nettype wire

// ==== rtl/ym_prims.sv ====
`timescale 1ns/1ns
`default_nettype none

module ym_sr_bit #(parameter int SR_LENGTH = 1)
	(
	input logic MCLK,
	input logic rst,
	input logic c1,
	input logic c2,
	input logic bit_in,
	output logic sr_out
	);

	logic [SR_LENGTH-1:0] v1;
	logic [SR_LENGTH-1:0] v2;
	logic [SR_LENGTH-1:0] v1_nxt;
	logic [SR_LENGTH-1:0] v2_nxt;

	generate
		if (SR_LENGTH == 1)
			assign v1_nxt = bit_in;
		else
			assign v1_nxt = {v2[SR_LENGTH-2:0], bit_in};
	endgenerate

	// slave stage is transparent during c2
	assign v2_nxt = c2 ? v1 : v2;
	assign sr_out = v2_nxt[SR_LENGTH-1];

	always_ff @(posedge MCLK)
	begin
		if (rst)
		begin
			v1 <= '0;
			v2 <= '0;
		end
		else
		begin
			if (c1)
				v1 <= v1_nxt;
			v2 <= v2_nxt;
		end
	end

endmodule

module ym_sr_bit_array #(parameter int SR_LENGTH = 1, parameter int DATA_WIDTH = 16)
	(
	input logic MCLK,
	input logic rst,
	input logic c1,
	input logic c2,
	input logic [DATA_WIDTH-1:0] data_in,
	output logic [DATA_WIDTH-1:0] data_out
	);

	genvar i;

	generate
		for (i = 0; i < DATA_WIDTH; i++)
		begin : g_bit
			ym_sr_bit #(.SR_LENGTH(SR_LENGTH)) i_sr
				(
				.MCLK(MCLK),
				.rst(rst),
				.c1(c1),
				.c2(c2),
				.bit_in(data_in[i]),
				.sr_out(data_out[i])
				);
		end
	endgenerate

endmodule

module ym_cnt_bit_load #(parameter int DATA_WIDTH = 1)
	(
	input logic MCLK,
	input logic rst,
	input logic c1,
	input logic c2,
	input logic c_in,
	input logic clear,
	input logic load,
	input logic [DATA_WIDTH-1:0] load_val,
	output logic [DATA_WIDTH-1:0] val,
	output logic c_out
	);

	logic [DATA_WIDTH-1:0] data_in;
	logic [DATA_WIDTH-1:0] data_out;
	logic [DATA_WIDTH:0] sum;

	ym_sr_bit_array #(.SR_LENGTH(1), .DATA_WIDTH(DATA_WIDTH)) i_mem
		(
		.MCLK(MCLK),
		.rst(rst),
		.c1(c1),
		.c2(c2),
		.data_in(data_in),
		.data_out(data_out)
		);

	assign sum = (load ? load_val : data_out) + c_in;
	assign data_in = clear ? '0 : sum[DATA_WIDTH-1:0];
	assign val = data_out;
	assign c_out = sum[DATA_WIDTH];

endmodule

module ym_dbg_read #(parameter int DATA_WIDTH = 1)
	(
	input logic MCLK,
	input logic rst,
	input logic c1,
	input logic c2,
	input logic load,
	input logic [DATA_WIDTH-1:0] load_val,
	output logic [DATA_WIDTH-1:0] val
	);

	logic [DATA_WIDTH-1:0] data_in;
	logic [DATA_WIDTH-1:0] data_out;

	ym_sr_bit_array #(.SR_LENGTH(1), .DATA_WIDTH(DATA_WIDTH)) i_mem
		(
		.MCLK(MCLK),
		.rst(rst),
		.c1(c1),
		.c2(c2),
		.data_in(data_in),
		.data_out(data_out)
		);

	assign data_in = load ? load_val : data_out; // recirculate when not loading
	assign val = data_out;

endmodule

`default_nettype wire

// ==== rtl/ym_pkg.sv ====
`default_nettype none

`include "ym_params.svh"

package ym_pkg;

	typedef enum logic [1:0]
	{
		OP_NONE = 2'd0,
		OP_FNUM = 2'd1,
		OP_CLEAR = 2'd2
	} ym_op_e;

	typedef struct packed
	{
		ym_op_e op;
		logic [1:0] lane;
		logic [2:0] slot;
		logic [`YM_PHASE_W-1:0] value;
	} ym_lane_cmd_t;

	typedef struct packed
	{
		logic c1;
		logic c2;
		logic [2:0] slot;
		logic round_start; // c1 of slot 0
	} ym_tick_t;

	typedef enum logic [1:0]
	{
		AX_IDLE = 2'd0,
		AX_WAIT_TAP = 2'd1,
		AX_RESP = 2'd2
	} ym_axi_state_e;

	typedef struct packed
	{
		logic valid;
		logic [1:0] lane;
		logic [2:0] slot;
	} ym_tap_req_t;

endpackage

`default_nettype wire

// ==== rtl/ym_params.svh ====
`ifndef YM_PARAMS_SVH
`define YM_PARAMS_SVH

// slots per round and operator lanes
`define YM_SLOTS 6
`define YM_LANES 4

// phase and frequency word width, round counter width
`define YM_PHASE_W 12
`define YM_STEP_W 8

// byte addresses on the AXI4-Lite port
`define YM_ADDR_CTRL 12'h000
`define YM_ADDR_STEP 12'h004
`define YM_ADDR_FNUM_BASE 12'h100
`define YM_ADDR_PHASE_BASE 12'h200

// FNUM and PHASE regions are selected by the upper nibble of the address
`define YM_ADDR_REGION_MASK 12'hf00

`endif
